//--- src/wb_defines.svh
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// result slots per retiring micro-op
`define WB_SLOTS 4

// width of one result word
`define WB_DATA_W 32

// entries in the memory write queue
`define WBAQ_DEPTH 4

// exception codes reported by writeback
`define IE_SEG_LIMIT 4'b0001
`define IE_INTERRUPT 4'b1000

`endif

//--- src/wb_pkg.sv
`include "wb_defines.svh"

package wb_pkg;

    typedef logic [`WB_DATA_W-1:0] word_t;   // result or address
    typedef logic [2:0] reg_idx_t;           // gpr or segment index
    typedef logic [1:0] opsize_t;            // 0 byte, 1 word, 2 dword, 3 far ptr
    typedef logic [3:0] ie_type_t;

    // one result slot of the retiring op
    typedef struct packed {
        word_t data;
        word_t dest;     // low bits index a register, full word is a mem address
        logic  is_reg;
        logic  is_seg;
        logic  is_mem;
        logic  wb;
    } wb_slot_t;

    // branch outcome from execute
    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  correct;
        word_t target;
    } br_info_t;

    typedef enum logic {
        RUN,
        HALTED
    } halt_state_t;

endpackage

//--- src/wb_route.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_route import wb_pkg::*; (
    input  wb_slot_t [`WB_SLOTS-1:0] slots,
    input  logic                     valid_out,
    input  opsize_t                  inpsize,
    input  logic [3:0]               memsize_ovr,
    input  logic                     op_far,
    output logic [`WB_SLOTS-1:0]     reg_ld,
    output logic [`WB_SLOTS-1:0]     seg_ld,
    output reg_idx_t [`WB_SLOTS-1:0] reg_addr,
    output reg_idx_t [`WB_SLOTS-1:0] seg_addr,
    output word_t [`WB_SLOTS-1:0]    res,
    output logic                     mem_any,
    output logic                     mem_ld,
    output word_t                    mem_addr,
    output word_t                    mem_data,
    output opsize_t                  memsize
);

    logic [`WB_SLOTS-1:0] mem_hit;   // slot wants memory, not yet gated

    genvar i;
    generate
        for (i = 0; i < `WB_SLOTS; i++) begin : g_slot
            assign reg_ld[i]   = slots[i].is_reg & slots[i].wb & valid_out;
            assign seg_ld[i]   = slots[i].is_seg & slots[i].wb & valid_out;
            assign mem_hit[i]  = slots[i].is_mem & slots[i].wb;
            assign reg_addr[i] = slots[i].dest[2:0];
            assign seg_addr[i] = slots[i].dest[2:0];
            if (i == 0) begin : g_far
                // far transfer keeps the CS selector in the upper half
                assign res[i] = op_far ? word_t'(slots[i].data >> 16) : slots[i].data;
            end else begin : g_pass
                assign res[i] = slots[i].data;
            end
        end
    endgenerate

    assign mem_any = |mem_hit;
    assign mem_ld  = mem_any & valid_out;

    // lowest memory slot wins, so scan downward
    always_comb begin
        mem_addr = '0;
        mem_data = '0;
        for (int s = `WB_SLOTS - 1; s >= 0; s--) begin
            if (mem_hit[s]) begin
                mem_addr = slots[s].dest;
                mem_data = slots[s].data;
            end
        end
    end

    always_comb begin
        memsize = op_far ? opsize_t'(2'd3) : inpsize;
        for (int k = 0; k < 4; k++) begin
            if (memsize_ovr[k]) begin
                memsize = opsize_t'(k);   // override bit k means size k
            end
        end
    end

endmodule

//--- src/wb_branch_check.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_branch_check import wb_pkg::*; (
    input  logic        valid_in,
    input  logic        valid_out,
    input  br_info_t    br,
    input  logic        op_far,
    input  word_t       eip_in,
    input  word_t       slot0_data,
    input  logic [15:0] cs_in,
    input  logic [19:0] cs_lim,
    input  logic        ie_in,
    input  ie_type_t    ie_type_in,
    input  logic        interrupt_in,
    input  logic        halted,
    output word_t       new_eip,
    output word_t       new_fip,
    output logic        seg_fault,
    output logic        resteer,
    output logic        final_ie_val,
    output ie_type_t    final_ie_type
);

    word_t target;
    word_t line_end;
    word_t cs_max;
    logic  op_live;
    logic  op_ie;

    // far jumps take EIP from slot 0
    assign target   = op_far ? slot0_data : br.target;
    assign new_eip  = br.taken ? target : eip_in;
    assign new_fip  = {target[`WB_DATA_W-1:4], 4'h0};
    assign line_end = {target[`WB_DATA_W-1:4], 4'hf};   // last byte of the fetch line

    assign cs_max = word_t'({cs_in, 4'h0}) + word_t'(cs_lim);

    // a halted core retires nothing, so only interrupts count there
    assign op_live = valid_in & ~halted;
    assign op_ie   = ie_in & op_live;

    assign seg_fault = op_live & br.valid & br.taken & (line_end >= cs_max);

    assign final_ie_val = op_ie | seg_fault | interrupt_in;

    always_comb begin
        if (op_ie) begin
            final_ie_type = ie_type_in;
        end else if (seg_fault) begin
            final_ie_type = `IE_SEG_LIMIT;
        end else if (interrupt_in) begin
            final_ie_type = `IE_INTERRUPT;
        end else begin
            final_ie_type = '0;
        end
    end

    // mispredict only redirects fetch when the op really retires
    assign resteer = valid_out & br.valid & ~br.correct & ~final_ie_val;

endmodule

//--- src/wb_halt_fsm.sv
`timescale 1ns/1ps

module wb_halt_fsm import wb_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic retire_halt,
    input  logic interrupt_in,
    output logic halted
);

    halt_state_t state;
    halt_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            RUN: begin
                if (retire_halt) begin
                    state_nxt = HALTED;
                end
            end
            HALTED: begin
                if (interrupt_in) begin
                    state_nxt = RUN;   // wakeup
                end
            end
            default: state_nxt = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            state <= state_nxt;
        end
    end

    assign halted = (state == HALTED);

    // retire is gated by halted in the top level, so no HLT can retire while halted
    a_no_halt_when_halted: assert property (
        @(posedge clk) disable iff (rst) (state == HALTED) |-> !retire_halt
    );

endmodule

//--- src/wbaq_credit.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wbaq_credit (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic drain,
    output logic full
);

    localparam int CNT_W = $clog2(`WBAQ_DEPTH + 1);

    logic [CNT_W-1:0] count;   // entries held in the queue

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (push && !drain) begin
            count <= count + 1'b1;
        end else if (drain && !push) begin
            count <= count - 1'b1;
        end
    end

    assign full = (count == CNT_W'(`WBAQ_DEPTH));

    // memory side only retires entries it holds
    a_no_drain_empty: assert property (
        @(posedge clk) disable iff (rst) drain |-> (count != '0)
    );

    // stall logic upstream must hold pushes off a full queue
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    );

endmodule

//--- src/writeback_top.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module writeback_top import wb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid_in,
    input  wb_slot_t [`WB_SLOTS-1:0] slots,
    input  opsize_t                  inpsize,
    input  logic [3:0]               memsize_ovr,
    input  word_t                    eip_in,
    input  logic [15:0]              cs_in,
    input  logic [19:0]              cs_lim,
    input  br_info_t                 br,
    input  logic                     op_halt,
    input  logic                     op_far,
    input  logic                     ie_in,
    input  ie_type_t                 ie_type_in,
    input  logic                     interrupt_in,
    input  logic                     wbaq_drain,
    output logic                     valid_out,
    output logic [`WB_SLOTS-1:0]     reg_ld,
    output logic [`WB_SLOTS-1:0]     seg_ld,
    output reg_idx_t [`WB_SLOTS-1:0] reg_addr,
    output reg_idx_t [`WB_SLOTS-1:0] seg_addr,
    output word_t [`WB_SLOTS-1:0]    res,
    output logic                     mem_ld,
    output word_t                    mem_addr,
    output word_t                    mem_data,
    output opsize_t                  memsize,
    output word_t                    new_eip,
    output word_t                    new_fip,
    output logic                     resteer,
    output logic                     final_ie_val,
    output ie_type_t                 final_ie_type,
    output logic                     halted,
    output logic                     stall
);

    logic mem_any;
    logic seg_fault;
    logic wbaq_full;
    logic retire_halt;

    // hold the op while its memory write has no queue credit
    assign stall       = valid_in & mem_any & wbaq_full;
    assign valid_out   = valid_in & ~stall & ~halted & ~final_ie_val;
    assign retire_halt = op_halt & valid_out;

    wb_route u_route (
        .slots       (slots),
        .valid_out   (valid_out),
        .inpsize     (inpsize),
        .memsize_ovr (memsize_ovr),
        .op_far      (op_far),
        .reg_ld      (reg_ld),
        .seg_ld      (seg_ld),
        .reg_addr    (reg_addr),
        .seg_addr    (seg_addr),
        .res         (res),
        .mem_any     (mem_any),
        .mem_ld      (mem_ld),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .memsize     (memsize)
    );

    wb_branch_check u_branch (
        .valid_in      (valid_in),
        .valid_out     (valid_out),
        .br            (br),
        .op_far        (op_far),
        .eip_in        (eip_in),
        .slot0_data    (slots[0].data),
        .cs_in         (cs_in),
        .cs_lim        (cs_lim),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .halted        (halted),
        .new_eip       (new_eip),
        .new_fip       (new_fip),
        .seg_fault     (seg_fault),
        .resteer       (resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

    wb_halt_fsm u_halt (
        .clk          (clk),
        .rst          (rst),
        .retire_halt  (retire_halt),
        .interrupt_in (interrupt_in),
        .halted       (halted)
    );

    wbaq_credit u_credit (
        .clk   (clk),
        .rst   (rst),
        .push  (mem_ld),
        .drain (wbaq_drain),
        .full  (wbaq_full)
    );

    a_ovr_onehot: assert property (
        @(posedge clk) disable iff (rst) valid_in |-> $onehot0(memsize_ovr)
    );

    // write strobe and queue credit live in different blocks
    a_no_mem_ld_full: assert property (
        @(posedge clk) disable iff (rst) wbaq_full |-> !mem_ld
    );

    // a faulting branch neither retires nor redirects fetch
    a_seg_fault_blocks: assert property (
        @(posedge clk) disable iff (rst) seg_fault |-> (!valid_out && !resteer)
    );

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tb/writeback_tb.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module writeback_tb import wb_pkg::*; ();

    localparam word_t       EIP_BASE = 32'h0000_0100;
    localparam logic [15:0] CS_BASE  = 16'h0010;        // segment base 0x100
    localparam word_t       FAR_PTR  = 32'h0008_0400;   // selector 8, offset 0x400

    typedef struct packed {
        logic [3:0] is_reg;
        logic [3:0] is_seg;
        logic [3:0] is_mem;
        logic [3:0] wb;
    } flags_t;

    typedef struct packed {
        logic        valid;
        logic        far;
        logic        halt;
        logic        ie_in;
        logic        irq;
        logic        drain;
        flags_t      flags;
        opsize_t     inpsize;
        logic [3:0]  ovr;
        logic        br_valid;
        logic        br_taken;
        logic        br_correct;
        word_t       target;
        logic [19:0] lim;
        ie_type_t    ie_type;
    } stim_t;

    typedef struct packed {
        logic       valid_out;
        logic       stall;
        logic       halted;
        logic       mem_ld;
        logic       resteer;
        logic       ie_val;
        logic [3:0] reg_ld;
        logic [3:0] seg_ld;
        logic       has_mem;
        logic [1:0] mem_slot;
        opsize_t    memsize;
        logic [1:0] eip_src;   // 0 eip_in, 1 br target, 2 far pointer
        ie_type_t   ie_type;
    } expect_t;

    logic clk;
    logic rst;
    logic valid_in;
    wb_slot_t [`WB_SLOTS-1:0] slots;
    opsize_t inpsize;
    logic [3:0] memsize_ovr;
    word_t eip_in;
    logic [15:0] cs_in;
    logic [19:0] cs_lim;
    br_info_t br;
    logic op_halt;
    logic op_far;
    logic ie_in;
    ie_type_t ie_type_in;
    logic interrupt_in;
    logic wbaq_drain;
    logic valid_out;
    logic [`WB_SLOTS-1:0] reg_ld;
    logic [`WB_SLOTS-1:0] seg_ld;
    reg_idx_t [`WB_SLOTS-1:0] reg_addr;
    reg_idx_t [`WB_SLOTS-1:0] seg_addr;
    word_t [`WB_SLOTS-1:0] res;
    logic mem_ld;
    word_t mem_addr;
    word_t mem_data;
    opsize_t memsize;
    word_t new_eip;
    word_t new_fip;
    logic resteer;
    logic final_ie_val;
    ie_type_t final_ie_type;
    logic halted;
    logic stall;

    string   names[$];
    stim_t   stims[$];
    expect_t exps[$];
    word_t   cur_data[`WB_SLOTS];
    word_t   cur_dest[`WB_SLOTS];
    string   cur_name;
    integer  seed;
    int      row_errs;
    int      pass_cnt;
    int      fail_cnt;
    int      n_rows;
    logic    prev_stall;   // last op was held back

    tb_clkgen clkgen0 (.clk(clk), .rst(rst));

    writeback_top dut0 (.*);

    task add_row(input stim_t s, input expect_t e, input string name);
        stims.push_back(s);
        exps.push_back(e);
        names.push_back(name);
    endtask

    task compare_field(input string field, input word_t exp_v, input word_t act_v);
        assert (act_v === exp_v) else begin
            $display("[FAIL] %s: %s expected %h actual %h", cur_name, field, exp_v, act_v);
            row_errs++;
        end
    endtask

    // stim: {valid far halt ie irq drain} {reg seg mem wb} inpsize ovr {v t c} target lim ie
    // expect: {vout stall halted mem_ld resteer ie} reg_ld seg_ld mem eip_src... see expect_t
    task build_table();
        add_row({6'b000000, 16'h0000, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b000000, 4'h0, 4'h0, 3'b000, 2'd0, 2'd0, 4'h0}, "idle");
        add_row({6'b100000, 16'h58af, 2'd2, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100100, 4'h5, 4'h8, 3'b101, 2'd2, 2'd0, 4'h0}, "route_mix");
        add_row({6'b100000, 16'h3c06, 2'd1, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100000, 4'h2, 4'h4, 3'b000, 2'd1, 2'd0, 4'h0}, "route_wb_mask");
        add_row({6'b110000, 16'h0011, 2'd0, 4'h2, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100100, 4'h0, 4'h0, 3'b100, 2'd1, 2'd0, 4'h0}, "size_ovr");
        add_row({6'b110000, 16'h0011, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100100, 4'h0, 4'h0, 3'b100, 2'd3, 2'd0, 4'h0}, "size_far");
        add_row({6'b100000, 16'h0044, 2'd1, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100100, 4'h0, 4'h0, 3'b110, 2'd1, 2'd0, 4'h0}, "size_inp");
        add_row({6'b100000, 16'h2013, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b010000, 4'h0, 4'h0, 3'b100, 2'd0, 2'd0, 4'h0}, "queue_full");
        add_row({6'b100001, 16'h2013, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b010000, 4'h0, 4'h0, 3'b100, 2'd0, 2'd0, 4'h0}, "queue_drain");
        add_row({6'b100000, 16'h2013, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100100, 4'h2, 4'h0, 3'b100, 2'd0, 2'd0, 4'h0}, "queue_resume");
        add_row({6'b100000, 16'h0000, 2'd0, 4'h0, 3'b111, 32'h0000_1230, 20'hfffff, 4'h0},
                {6'b100000, 4'h0, 4'h0, 3'b000, 2'd0, 2'd1, 4'h0}, "br_taken");
        add_row({6'b100000, 16'h0000, 2'd0, 4'h0, 3'b100, 32'h0000_1230, 20'hfffff, 4'h0},
                {6'b100010, 4'h0, 4'h0, 3'b000, 2'd0, 2'd0, 4'h0}, "br_nt_miss");
        add_row({6'b100000, 16'h0000, 2'd0, 4'h0, 3'b110, 32'h0000_1230, 20'hfffff, 4'h0},
                {6'b100010, 4'h0, 4'h0, 3'b000, 2'd0, 2'd1, 4'h0}, "br_taken_miss");
        add_row({6'b110000, 16'h0000, 2'd0, 4'h0, 3'b111, 32'h0, 20'hfffff, 4'h0},
                {6'b100000, 4'h0, 4'h0, 3'b000, 2'd3, 2'd2, 4'h0}, "far_jump");
        // cs base 0x100 plus limit 0xeff puts the boundary at 0xfff
        add_row({6'b100000, 16'h1001, 2'd0, 4'h0, 3'b110, 32'h0000_0ff8, 20'h00eff, 4'h0},
                {6'b000001, 4'h0, 4'h0, 3'b000, 2'd0, 2'd1, 4'h1}, "seg_limit");
        add_row({6'b100000, 16'h1001, 2'd0, 4'h0, 3'b110, 32'h0000_0fe0, 20'h00eff, 4'h0},
                {6'b100010, 4'h1, 4'h0, 3'b000, 2'd0, 2'd1, 4'h0}, "seg_limit_below");
        add_row({6'b100100, 16'h1001, 2'd0, 4'h0, 3'b110, 32'h0000_0ff8, 20'h00eff, 4'h4},
                {6'b000001, 4'h0, 4'h0, 3'b000, 2'd0, 2'd1, 4'h4}, "ie_priority");
        add_row({6'b100010, 16'h0000, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b000001, 4'h0, 4'h0, 3'b000, 2'd0, 2'd0, 4'h8}, "irq_running");
        add_row({6'b101000, 16'h0000, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100000, 4'h0, 4'h0, 3'b000, 2'd0, 2'd0, 4'h0}, "halt_retire");
        add_row({6'b100000, 16'h1001, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b001000, 4'h0, 4'h0, 3'b000, 2'd0, 2'd0, 4'h0}, "halted_hold");
        add_row({6'b000010, 16'h0000, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b001001, 4'h0, 4'h0, 3'b000, 2'd0, 2'd0, 4'h8}, "wake_irq");
        add_row({6'b100000, 16'h1001, 2'd0, 4'h0, 3'b000, 32'h0, 20'hfffff, 4'h0},
                {6'b100000, 4'h1, 4'h0, 3'b000, 2'd0, 2'd0, 4'h0}, "after_wake");
    endtask

    task drive_row(input stim_t s, input logic hold);
        for (int k = 0; k < `WB_SLOTS; k++) begin
            if (!hold) begin   // a stalled op stays on the bus unchanged
                cur_data[k] = $random(seed);
                cur_dest[k] = $random(seed);
            end
            if (k == 0 && s.far) begin
                cur_data[k] = FAR_PTR;   // CS:EIP of the far transfer
            end
            slots[k].data   = cur_data[k];
            slots[k].dest   = cur_dest[k];
            slots[k].is_reg = s.flags.is_reg[k];
            slots[k].is_seg = s.flags.is_seg[k];
            slots[k].is_mem = s.flags.is_mem[k];
            slots[k].wb     = s.flags.wb[k];
        end
        valid_in     = s.valid;
        inpsize      = s.inpsize;
        memsize_ovr  = s.ovr;
        cs_lim       = s.lim;
        br.valid     = s.br_valid;
        br.taken     = s.br_taken;
        br.correct   = s.br_correct;
        br.target    = s.target;
        op_halt      = s.halt;
        op_far       = s.far;
        ie_in        = s.ie_in;
        ie_type_in   = s.ie_type;
        interrupt_in = s.irq;
        wbaq_drain   = s.drain;
    endtask

    task verify_row(input stim_t s, input expect_t e);
        word_t tgt;
        word_t eip_exp;
        tgt = s.far ? FAR_PTR : s.target;
        case (e.eip_src)
            2'd1: eip_exp = s.target;
            2'd2: eip_exp = FAR_PTR;
            default: eip_exp = EIP_BASE;
        endcase
        compare_field("valid_out", word_t'(e.valid_out), word_t'(valid_out));
        compare_field("stall", word_t'(e.stall), word_t'(stall));
        compare_field("halted", word_t'(e.halted), word_t'(halted));
        compare_field("mem_ld", word_t'(e.mem_ld), word_t'(mem_ld));
        compare_field("resteer", word_t'(e.resteer), word_t'(resteer));
        compare_field("final_ie_val", word_t'(e.ie_val), word_t'(final_ie_val));
        compare_field("final_ie_type", word_t'(e.ie_type), word_t'(final_ie_type));
        compare_field("reg_ld", word_t'(e.reg_ld), word_t'(reg_ld));
        compare_field("seg_ld", word_t'(e.seg_ld), word_t'(seg_ld));
        compare_field("memsize", word_t'(e.memsize), word_t'(memsize));
        compare_field("new_eip", eip_exp, new_eip);
        compare_field("new_fip", tgt & 32'hffff_fff0, new_fip);
        compare_field("res0", s.far ? cur_data[0] >> 16 : cur_data[0], res[0]);
        if (e.has_mem) begin
            compare_field("mem_addr", cur_dest[e.mem_slot], mem_addr);
            compare_field("mem_data", cur_data[e.mem_slot], mem_data);
        end
        for (int k = 0; k < `WB_SLOTS; k++) begin
            compare_field("reg_addr", word_t'(cur_dest[k][2:0]), word_t'(reg_addr[k]));
            compare_field("seg_addr", word_t'(cur_dest[k][2:0]), word_t'(seg_addr[k]));
            if (k > 0) begin
                compare_field("res", cur_data[k], res[k]);
            end
        end
    endtask

    initial begin
        seed         = 32'h3be2a400;
        pass_cnt     = 0;
        fail_cnt     = 0;
        n_rows       = 0;
        prev_stall   = 1'b0;
        valid_in     = 1'b0;
        slots        = '0;
        inpsize      = '0;
        memsize_ovr  = '0;
        eip_in       = EIP_BASE;
        cs_in        = CS_BASE;
        cs_lim       = '0;
        br           = '0;
        op_halt      = 1'b0;
        op_far       = 1'b0;
        ie_in        = 1'b0;
        ie_type_in   = '0;
        interrupt_in = 1'b0;
        wbaq_drain   = 1'b0;
        build_table();
        n_rows = names.size();
        @(negedge clk);
        while (rst) @(negedge clk);
        for (int i = 0; i < n_rows; i++) begin
            cur_name = names[i];
            row_errs = 0;
            drive_row(stims[i], prev_stall);
            #1;   // outputs settle well before the rising edge
            verify_row(stims[i], exps[i]);
            prev_stall = stall;
            if (row_errs == 0) begin
                pass_cnt++;
                $display("[ OK ] %s", cur_name);
            end else begin
                fail_cnt++;
                $display("[BAD ] %s, %0d mismatches", cur_name, row_errs);
            end
            @(negedge clk);
        end
        $display("%0d tests run, %0d passed, %0d failed", n_rows, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // four cycles per row, plus reset and slack
    initial begin
        wait (n_rows > 0);
        #((n_rows * 4 + 16 + 20) * 4);
        $display("watchdog expired before the row loop finished");
        $display("tests failed");
        $finish;
    end

endmodule

//--- all.f
+incdir+src
src/wb_pkg.sv
src/wb_route.sv
src/wb_branch_check.sv
src/wb_halt_fsm.sv
src/wbaq_credit.sv
src/writeback_top.sv
tb/tb_clkgen.sv
tb/writeback_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= writeback_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG) || \
	    ! grep -q "all tests passed" $(LOG); then \
	    echo "simulation did not pass, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
